/* design/mips_pkg.sv */
package mips_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // SPECIAL funct field
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        word_t     opa;     // rs value, or shift amount
        word_t     opb;     // rt value or extended immediate
        reg_addr_t wd;
        logic      wreg;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
    } ex_wb_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_write_t;

endpackage

/* design/regfile.sv */
module regfile (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::wb_write_t wr_i,
    input  mips_pkg::reg_addr_t raddr1_i,
    input  mips_pkg::reg_addr_t raddr2_i,
    output mips_pkg::word_t     rdata1_o,
    output mips_pkg::word_t     rdata2_o
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_i.we && wr_i.waddr == addr) begin
            return wr_i.wdata;  // write-through
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.waddr != '0) begin
            regs[wr_i.waddr] <= wr_i.wdata;
        end
    end

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

/* design/decode_stage.sv */
module decode_stage #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid_i,
    input  mips_pkg::word_t     inst_i,
    output mips_pkg::reg_addr_t raddr1_o,
    output mips_pkg::reg_addr_t raddr2_o,
    input  mips_pkg::word_t     rdata1_i,
    input  mips_pkg::word_t     rdata2_i,
    input  mips_pkg::ex_wb_t    fwd_i,
    output mips_pkg::id_ex_t    id_ex_o
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    logic [15:0] imm;
    word_t       imm_sext;
    word_t       imm_zext;
    word_t       reg1;
    word_t       reg2;
    word_t       pc_q;      // pc of the next accepted instruction
    id_ex_t      id_ex_d;
    id_ex_t      id_ex_q;

    // take the result still in EX if it targets this register
    function automatic word_t fwd_sel(input reg_addr_t addr, input word_t rdata,
                                      input ex_wb_t fwd);
        if (fwd.valid && fwd.wreg && addr != '0 && fwd.wd == addr) begin
            return fwd.wdata;
        end
        return rdata;
    endfunction

    assign opcode   = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign sa       = inst_i[10:6];
    assign funct    = inst_i[5:0];
    assign imm      = inst_i[15:0];
    assign imm_sext = {{(WORD_W - 16){imm[15]}}, imm};
    assign imm_zext = {{(WORD_W - 16){1'b0}}, imm};

    assign raddr1_o = rs;
    assign raddr2_o = rt;
    assign reg1     = fwd_sel(rs, rdata1_i, fwd_i);
    assign reg2     = fwd_sel(rt, rdata2_i, fwd_i);

    always_comb begin
        id_ex_d.valid  = inst_valid_i;
        id_ex_d.pc     = pc_q;
        id_ex_d.alu_op = ALU_ADD;
        id_ex_d.opa    = reg1;
        id_ex_d.opb    = imm_sext;
        id_ex_d.wd     = rt;    // I-type writes rt
        id_ex_d.wreg   = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                id_ex_d.wd  = rd;
                id_ex_d.opb = reg2;
                case (funct)
                    FN_ADDU: id_ex_d.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_d.alu_op = ALU_SUB;
                    FN_AND:  id_ex_d.alu_op = ALU_AND;
                    FN_OR:   id_ex_d.alu_op = ALU_OR;
                    FN_XOR:  id_ex_d.alu_op = ALU_XOR;
                    FN_NOR:  id_ex_d.alu_op = ALU_NOR;
                    FN_SLT:  id_ex_d.alu_op = ALU_SLT;
                    FN_SLTU: id_ex_d.alu_op = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        id_ex_d.opa = {{(WORD_W - 5){1'b0}}, sa};
                        id_ex_d.alu_op = (funct == FN_SLL) ? ALU_SLL :
                                         (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    default: id_ex_d.wreg = 1'b0;
                endcase
            end
            OP_ADDIU: id_ex_d.alu_op = ALU_ADD;
            OP_SLTI:  id_ex_d.alu_op = ALU_SLT;
            OP_SLTIU: id_ex_d.alu_op = ALU_SLTU;   // sign-extended, compared unsigned
            OP_ANDI: begin
                id_ex_d.alu_op = ALU_AND;
                id_ex_d.opb    = imm_zext;
            end
            OP_ORI: begin
                id_ex_d.alu_op = ALU_OR;
                id_ex_d.opb    = imm_zext;
            end
            OP_XORI: begin
                id_ex_d.alu_op = ALU_XOR;
                id_ex_d.opb    = imm_zext;
            end
            OP_LUI: begin
                id_ex_d.alu_op = ALU_LUI;
                id_ex_d.opb    = imm_zext;
            end
            default: id_ex_d.wreg = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q          <= RESET_PC;
            id_ex_q.valid <= 1'b0;
        end else begin
            id_ex_q <= id_ex_d;
            if (inst_valid_i) begin
                pc_q <= pc_q + 32'd4;   // idle cycles hold the pc
            end
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

/* design/execute_stage.sv */
module execute_stage (
    input  logic             clk,
    input  logic             rst,
    input  mips_pkg::id_ex_t id_ex_i,
    output mips_pkg::ex_wb_t fwd_o,
    output mips_pkg::ex_wb_t ex_wb_o
);
    import mips_pkg::*;

    word_t      opa;
    word_t      opb;
    logic [4:0] shamt;
    word_t      result;
    ex_wb_t     ex_wb_d;
    ex_wb_t     ex_wb_q;

    assign opa   = id_ex_i.opa;
    assign opb   = id_ex_i.opb;
    assign shamt = opa[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_AND:  result = opa & opb;
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_NOR:  result = ~(opa | opb);
            ALU_SLT:  result = {{(WORD_W - 1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU: result = {{(WORD_W - 1){1'b0}}, opa < opb};
            ALU_SLL:  result = opb << shamt;
            ALU_SRL:  result = opb >> shamt;
            ALU_SRA:  result = $signed(opb) >>> shamt;
            ALU_LUI:  result = {opb[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    always_comb begin
        ex_wb_d.valid = id_ex_i.valid;
        ex_wb_d.pc    = id_ex_i.pc;
        ex_wb_d.wd    = id_ex_i.wd;
        ex_wb_d.wreg  = id_ex_i.wreg;
        ex_wb_d.wdata = result;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_wb_q.valid <= 1'b0;
        end else begin
            ex_wb_q <= ex_wb_d;
        end
    end

    assign fwd_o   = ex_wb_d;  // seen by decode one cycle early
    assign ex_wb_o = ex_wb_q;

endmodule

/* design/writeback_stage.sv */
module writeback_stage (
    input  mips_pkg::ex_wb_t    ex_wb_i,
    output mips_pkg::wb_write_t wr_o,
    output mips_pkg::word_t     debug_wb_pc_o,
    output logic [3:0]          debug_wb_rf_wen_o,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output mips_pkg::word_t     debug_wb_rf_wdata_o
);
    import mips_pkg::*;

    logic we;

    // $zero writes are dropped here, so they never show on the trace
    assign we = ex_wb_i.valid && ex_wb_i.wreg && (ex_wb_i.wd != '0);

    always_comb begin
        wr_o.we    = we;
        wr_o.waddr = ex_wb_i.wd;
        wr_o.wdata = ex_wb_i.wdata;
    end

    assign debug_wb_pc_o       = ex_wb_i.pc;
    assign debug_wb_rf_wen_o   = {4{we}};   // all byte lanes
    assign debug_wb_rf_wnum_o  = ex_wb_i.wd;
    assign debug_wb_rf_wdata_o = ex_wb_i.wdata;

endmodule

/* design/mips_core.sv */
module mips_core #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc00000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid_i,
    input  mips_pkg::word_t     inst_i,
    output mips_pkg::word_t     debug_wb_pc_o,
    output logic [3:0]          debug_wb_rf_wen_o,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output mips_pkg::word_t     debug_wb_rf_wdata_o
);
    import mips_pkg::*;

    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;
    id_ex_t    id_ex;
    ex_wb_t    ex_fwd;  // unregistered next EX/WB value
    ex_wb_t    ex_wb;
    wb_write_t wb_wr;

    decode_stage #(
        .RESET_PC(RESET_PC)
    ) decode0 (
        .clk(clk), .rst(rst),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .raddr1_o(raddr1), .raddr2_o(raddr2),
        .rdata1_i(rdata1), .rdata2_i(rdata2),
        .fwd_i(ex_fwd),
        .id_ex_o(id_ex)
    );

    regfile regfile0 (
        .clk(clk), .rst(rst),
        .wr_i(wb_wr),
        .raddr1_i(raddr1), .raddr2_i(raddr2),
        .rdata1_o(rdata1), .rdata2_o(rdata2)
    );

    execute_stage execute0 (
        .clk(clk), .rst(rst),
        .id_ex_i(id_ex),
        .fwd_o(ex_fwd),
        .ex_wb_o(ex_wb)
    );

    writeback_stage writeback0 (
        .ex_wb_i(ex_wb),
        .wr_o(wb_wr),
        .debug_wb_pc_o(debug_wb_pc_o),
        .debug_wb_rf_wen_o(debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

endmodule

/* test/mips_test_table.svh */
`ifndef MIPS_TEST_TABLE_SVH
`define MIPS_TEST_TABLE_SVH

// each row holds the instruction word, write flag, register number and write data
typedef struct packed {
    word_t     inst;
    logic      wen;
    reg_addr_t wnum;
    word_t     wdata;
} test_entry_t;

localparam int NUM_TESTS = 30;

localparam test_entry_t TEST_TABLE [NUM_TESTS] = '{
    '{32'h3401_1234, 1'b1, 5'd1,  32'h0000_1234},  // ori   r1, r0, 0x1234
    '{32'h3c02_8000, 1'b1, 5'd2,  32'h8000_0000},  // lui   r2, 0x8000
    '{32'h2423_ffff, 1'b1, 5'd3,  32'h0000_1233},  // addiu r3, r1, -1
    '{32'h2464_8000, 1'b1, 5'd4,  32'hffff_9233},  // addiu r4, r3, -32768
    '{32'h3085_f0f0, 1'b1, 5'd5,  32'h0000_9030},  // andi  r5, r4, 0xf0f0
    '{32'h3886_ffff, 1'b1, 5'd6,  32'hffff_6dcc},  // xori  r6, r4, 0xffff
    '{32'h2887_ffff, 1'b1, 5'd7,  32'h0000_0001},  // slti  r7, r4, -1
    '{32'h2c28_ffff, 1'b1, 5'd8,  32'h0000_0001},  // sltiu r8, r1, -1
    '{32'h2c89_0005, 1'b1, 5'd9,  32'h0000_0000},  // sltiu r9, r4, 5
    '{32'h0022_5021, 1'b1, 5'd10, 32'h8000_1234},  // addu  r10, r1, r2
    '{32'h0023_5823, 1'b1, 5'd11, 32'h0000_0001},  // subu  r11, r1, r3
    '{32'h0144_6024, 1'b1, 5'd12, 32'h8000_1230},  // and   r12, r10, r4
    '{32'h0186_6825, 1'b1, 5'd13, 32'hffff_7ffc},  // or    r13, r12, r6
    '{32'h01a1_7026, 1'b1, 5'd14, 32'hffff_6dc8},  // xor   r14, r13, r1
    '{32'h0020_7827, 1'b1, 5'd15, 32'hffff_edcb},  // nor   r15, r1, r0
    '{32'h0041_802a, 1'b1, 5'd16, 32'h0000_0001},  // slt   r16, r2, r1
    '{32'h0041_882b, 1'b1, 5'd17, 32'h0000_0000},  // sltu  r17, r2, r1
    '{32'h0001_9100, 1'b1, 5'd18, 32'h0001_2340},  // sll   r18, r1, 4
    '{32'h0002_9a02, 1'b1, 5'd19, 32'h0080_0000},  // srl   r19, r2, 8
    '{32'h0002_a203, 1'b1, 5'd20, 32'hff80_0000},  // sra   r20, r2, 8
    '{32'h3420_ffff, 1'b0, 5'd0,  32'h0000_0000},  // ori   r0, r1, 0xffff
    '{32'h0001_a821, 1'b1, 5'd21, 32'h0000_1234},  // addu  r21, r0, r1
    '{32'h8c16_0000, 1'b0, 5'd0,  32'h0000_0000},  // lw is not decoded
    '{32'h0022_b020, 1'b0, 5'd0,  32'h0000_0000},  // add is not decoded
    '{32'h26d6_0001, 1'b1, 5'd22, 32'h0000_0001},  // addiu r22, r22, 1
    '{32'h26d8_7fff, 1'b1, 5'd24, 32'h0000_8000},  // addiu r24, r22, 0x7fff
    '{32'h0316_c823, 1'b1, 5'd25, 32'h0000_7fff},  // subu  r25, r24, r22
    '{32'h0019_d7c0, 1'b1, 5'd26, 32'h8000_0000},  // sll   r26, r25, 31
    '{32'h001a_dfc3, 1'b1, 5'd27, 32'hffff_ffff},  // sra   r27, r26, 31
    '{32'h035b_e02a, 1'b1, 5'd28, 32'h0000_0001}   // slt   r28, r26, r27
};

`endif

/* test/tb_mips_core.sv */
module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    `include "mips_test_table.svh"

    localparam word_t RESET_PC       = 32'hbfc00000;
    localparam int    TIMEOUT_CYCLES = NUM_TESTS * 3 + 40;

    logic      clk = 1'b0;
    logic      rst;
    logic      inst_valid_i;
    word_t     inst_i;
    word_t     debug_wb_pc_o;
    logic [3:0] debug_wb_rf_wen_o;
    reg_addr_t debug_wb_rf_wnum_o;
    word_t     debug_wb_rf_wdata_o;

    integer seed;
    int     gap;
    int     error_count = 0;
    int     exp_idx = 0;    // next table entry the trace should match
    int     missing;
    int     cycle_count;

    mips_core #(
        .RESET_PC(RESET_PC)
    ) mips_core_inst (
        .clk(clk),
        .rst(rst),
        .inst_valid_i(inst_valid_i),
        .inst_i(inst_i),
        .debug_wb_pc_o(debug_wb_pc_o),
        .debug_wb_rf_wen_o(debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // trace monitor matches one table entry per write
    always @(posedge clk) begin
        if (!rst && debug_wb_rf_wen_o != 4'h0) begin
            while (exp_idx < NUM_TESTS && !TEST_TABLE[exp_idx].wen) begin
                exp_idx++;  // skip entries that write nothing
            end
            if (exp_idx >= NUM_TESTS) begin
                error_count++;
                $display("unexpected register write to r%0d at pc %h",
                         debug_wb_rf_wnum_o, debug_wb_pc_o);
            end else begin
                check("debug_wb_rf_wen_o", {28'h0, debug_wb_rf_wen_o}, 32'h0000_000f);
                check("debug_wb_pc_o", debug_wb_pc_o, RESET_PC + 32'(4 * exp_idx));
                check("debug_wb_rf_wnum_o", {27'h0, debug_wb_rf_wnum_o},
                      {27'h0, TEST_TABLE[exp_idx].wnum});
                check("debug_wb_rf_wdata_o", debug_wb_rf_wdata_o, TEST_TABLE[exp_idx].wdata);
                exp_idx++;
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d", error_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        seed         = 65663;
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // trace must stay quiet before the first strobe
        repeat (3) begin
            @(negedge clk);
            check("debug_wb_rf_wen_o", {28'h0, debug_wb_rf_wen_o}, 32'h0);
        end

        for (int i = 0; i < NUM_TESTS; i++) begin
            inst_valid_i = 1'b1;
            inst_i       = TEST_TABLE[i].inst;
            @(negedge clk);
            inst_valid_i = 1'b0;
            inst_i       = '0;
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
        end
        repeat (4) @(negedge clk);  // drain the pipeline

        missing = 0;
        for (int j = exp_idx; j < NUM_TESTS; j++) begin
            if (TEST_TABLE[j].wen) begin
                missing++;
            end
        end
        if (missing != 0) begin
            error_count += missing;
            $display("%0d expected register writes never showed up on the trace", missing);
        end

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+test
design/mips_pkg.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/mips_core.sv
test/tb_mips_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_mips_core -f sources.f \
    --Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > "$log" 2>&1 \
    || { echo "build or run failed"; cat build.log "$log" 2>/dev/null; exit 1; }

cat "$log"
grep -q "^ALL TESTS PASSED$" "$log" && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1
